// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = rv_core_tb
FILELIST = rv_core.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/rv_core.sv ====
`timescale 1ns/100ps

module rv_core import rv_pkg::*; #(
	parameter logic [31:0] RESET_VECTOR = 32'h8000_0000
) (
	input  logic        clk,
	input  logic        reset,
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_rdata,
	output dmem_req_s   dmem_req,
	input  logic [31:0] dmem_rdata,
	output logic        halt
);

	rv_inst_u    inst;
	ctrl_s       ctrl;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [4:0]  rd;
	logic [31:0] imm;
	logic [11:0] csr_addr;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] pc;
	logic [31:0] alu_result;
	logic        branch_taken;
	logic [31:0] target;
	logic [31:0] mem_addr;
	logic [31:0] csr_rdata;
	logic [31:0] trap_pc;
	logic        reg_wen;
	logic [31:0] wb_data;

	assign inst      = imem_rdata;
	assign imem_addr = pc;
	assign halt      = ctrl.is_ebreak;

	rv_decode u_decode (
		.inst     (inst),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.imm      (imm),
		.csr_addr (csr_addr),
		.ctrl     (ctrl)
	);

	rv_regfile u_regfile (
		.clk    (clk),
		.wen    (reg_wen),
		.waddr  (rd),
		.wdata  (wb_data),
		.raddr1 (rs1),
		.raddr2 (rs2),
		.rdata1 (src1),
		.rdata2 (src2)
	);

	rv_execute u_execute (
		.pc           (pc),
		.src1         (src1),
		.src2         (src2),
		.imm          (imm),
		.ctrl         (ctrl),
		.alu_result   (alu_result),
		.branch_taken (branch_taken),
		.target       (target),
		.mem_addr     (mem_addr)
	);

	rv_csr_file u_csr_file (
		.clk       (clk),
		.reset     (reset),
		.pc        (pc),
		.csr_addr  (csr_addr),
		.src1      (src1),
		.ctrl      (ctrl),
		.csr_rdata (csr_rdata),
		.trap_pc   (trap_pc)
	);

	rv_retire #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_retire (
		.clk          (clk),
		.reset        (reset),
		.ctrl         (ctrl),
		.imm          (imm),
		.src2         (src2),
		.alu_result   (alu_result),
		.branch_taken (branch_taken),
		.target       (target),
		.mem_addr     (mem_addr),
		.csr_rdata    (csr_rdata),
		.trap_pc      (trap_pc),
		.dmem_rdata   (dmem_rdata),
		.pc           (pc),
		.dmem_req     (dmem_req),
		.reg_wen      (reg_wen),
		.wb_data      (wb_data)
	);

endmodule

// ==== logic/rv_csr_file.sv ====
`timescale 1ns/100ps

module rv_csr_file import rv_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] pc,
	input  logic [11:0] csr_addr,
	input  logic [31:0] src1,
	input  ctrl_s       ctrl,
	output logic [31:0] csr_rdata,
	output logic [31:0] trap_pc
);

	logic [31:0] mstatus;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic [31:0] mcause;
	logic [31:0] csr_wdata;

	always_comb begin
		case (csr_addr)
			CSR_MSTATUS: csr_rdata = mstatus;
			CSR_MTVEC:   csr_rdata = mtvec;
			CSR_MEPC:    csr_rdata = mepc;
			CSR_MCAUSE:  csr_rdata = mcause;
			default:     csr_rdata = 32'h0;
		endcase
	end

	// csrrs sets bits on top of the old value
	assign csr_wdata = (ctrl.csr_op == CSR_RW) ? src1 : (csr_rdata | src1);

	always_ff @(posedge clk) begin
		if (reset) begin
			mstatus <= '0;
			mtvec   <= '0;
			mepc    <= '0;
			mcause  <= '0;
		end else if (ctrl.is_ecall) begin
			mepc   <= pc;
			mcause <= MCAUSE_ECALL_M;
		end else if (ctrl.csr_op != CSR_NONE) begin
			case (csr_addr)
				CSR_MSTATUS: mstatus <= csr_wdata;
				CSR_MTVEC:   mtvec   <= csr_wdata;
				// mepc holds word-aligned addresses only
				CSR_MEPC:    mepc    <= {csr_wdata[31:2], 2'b00};
				CSR_MCAUSE:  mcause  <= csr_wdata;
				default: begin
					mstatus <= mstatus;
				end
			endcase
		end
	end

	// direct mode only, mode bits of mtvec are ignored
	assign trap_pc = ctrl.is_mret ? mepc : {mtvec[31:2], 2'b00};

endmodule

// ==== logic/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode import rv_pkg::*; (
	input  rv_inst_u    inst,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	output logic [4:0]  rd,
	output logic [31:0] imm,
	output logic [11:0] csr_addr,
	output ctrl_s       ctrl
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	// alt selects sub or sra, funct7 bit 5
	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: alu_decode = alt ? ALU_SUB : ALU_ADD;
			3'b001: alu_decode = ALU_SLL;
			3'b010: alu_decode = ALU_SLT;
			3'b011: alu_decode = ALU_SLTU;
			3'b100: alu_decode = ALU_XOR;
			3'b101: alu_decode = alt ? ALU_SRA : ALU_SRL;
			3'b110: alu_decode = ALU_OR;
			default: alu_decode = ALU_AND;
		endcase
	endfunction

	assign opcode   = inst.r_fmt.opcode;
	assign funct3   = inst.r_fmt.funct3;
	assign funct7   = inst.r_fmt.funct7;
	assign rs1      = inst.r_fmt.rs1;
	assign rs2      = inst.r_fmt.rs2;
	assign rd       = inst.r_fmt.rd;
	assign csr_addr = inst.i_fmt.imm_11_0;

	// sign-extended immediates per format
	assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
	assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
	assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
			inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
	assign imm_u = {inst.u_fmt.imm_31_12, 12'h000};
	assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
			inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

	always_comb begin
		ctrl = '0;
		imm  = '0;
		case (opcode)
			OP_LUI: begin
				imm          = imm_u;
				ctrl.reg_wen = 1'b1;
				ctrl.wb_sel  = WB_IMM;
			end
			OP_AUIPC: begin
				imm              = imm_u;
				ctrl.src1_is_pc  = 1'b1;
				ctrl.src2_is_imm = 1'b1;
				ctrl.reg_wen     = 1'b1;
			end
			OP_JAL: begin
				imm          = imm_j;
				ctrl.is_jal  = 1'b1;
				ctrl.reg_wen = 1'b1;
				ctrl.wb_sel  = WB_PC4;
			end
			OP_JALR: begin
				imm          = imm_i;
				ctrl.is_jalr = 1'b1;
				ctrl.reg_wen = 1'b1;
				ctrl.wb_sel  = WB_PC4;
			end
			OP_BRANCH: begin
				imm = imm_b;
				// funct3 010 and 011 are not branches
				if (funct3[2:1] != 2'b01) begin
					ctrl.is_branch   = 1'b1;
					ctrl.branch_cond = branch_cond_e'(funct3);
				end
			end
			OP_LOAD: begin
				imm = imm_i;
				// lw, lh, lbu, lhu only
				if (funct3 == 3'b010 || funct3 == 3'b001 || funct3 == 3'b100 ||
						funct3 == 3'b101) begin
					ctrl.is_load       = 1'b1;
					ctrl.reg_wen       = 1'b1;
					ctrl.wb_sel        = WB_MEM;
					ctrl.load_unsigned = funct3[2];
					ctrl.mem_size      = (funct3[1:0] == 2'b10) ? MEM_WORD :
							(funct3[1:0] == 2'b01) ? MEM_HALF : MEM_BYTE;
				end
			end
			OP_STORE: begin
				imm = imm_s;
				if (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b010) begin
					ctrl.is_store = 1'b1;
					ctrl.mem_size = (funct3 == 3'b010) ? MEM_WORD :
							(funct3 == 3'b001) ? MEM_HALF : MEM_BYTE;
				end
			end
			OP_IMM: begin
				imm              = imm_i;
				ctrl.src2_is_imm = 1'b1;
				ctrl.reg_wen     = 1'b1;
				// addi has no sub form, only the right shifts look at funct7
				ctrl.alu_op = alu_decode(funct3, (funct3 == 3'b101) && funct7[5]);
			end
			OP_REG: begin
				ctrl.reg_wen = 1'b1;
				ctrl.alu_op  = alu_decode(funct3, funct7[5]);
			end
			OP_SYSTEM: begin
				imm = imm_i;
				if (inst == INST_ECALL) begin
					ctrl.is_ecall = 1'b1;
				end else if (inst == INST_EBREAK) begin
					ctrl.is_ebreak = 1'b1;
				end else if (inst == INST_MRET) begin
					ctrl.is_mret = 1'b1;
				end else if (funct3 == 3'b001 || funct3 == 3'b010) begin
					ctrl.csr_op  = (funct3 == 3'b001) ? CSR_RW : CSR_RS;
					ctrl.reg_wen = 1'b1;
					ctrl.wb_sel  = WB_CSR;
				end
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

// ==== logic/rv_execute.sv ====
`timescale 1ns/100ps

module rv_execute import rv_pkg::*; (
	input  logic [31:0] pc,
	input  logic [31:0] src1,
	input  logic [31:0] src2,
	input  logic [31:0] imm,
	input  ctrl_s       ctrl,
	output logic [31:0] alu_result,
	output logic        branch_taken,
	output logic [31:0] target,
	output logic [31:0] mem_addr
);

	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [4:0]  shamt;
	logic        src_eq;
	logic        src_lt;
	logic        src_ltu;
	logic        cond_met;

	assign op_a  = ctrl.src1_is_pc ? pc : src1;
	assign op_b  = ctrl.src2_is_imm ? imm : src2;
	assign shamt = op_b[4:0];

	always_comb begin
		case (ctrl.alu_op)
			ALU_ADD:  alu_result = op_a + op_b;
			ALU_SUB:  alu_result = op_a - op_b;
			ALU_AND:  alu_result = op_a & op_b;
			ALU_OR:   alu_result = op_a | op_b;
			ALU_XOR:  alu_result = op_a ^ op_b;
			ALU_SLL:  alu_result = op_a << shamt;
			ALU_SRL:  alu_result = op_a >> shamt;
			ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
			ALU_SLT:  alu_result = {31'h0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_result = {31'h0, op_a < op_b};
			default:  alu_result = op_a + op_b;
		endcase
	end

	// branch compares always use the register values
	assign src_eq  = (src1 == src2);
	assign src_lt  = ($signed(src1) < $signed(src2));
	assign src_ltu = (src1 < src2);

	always_comb begin
		case (ctrl.branch_cond)
			BR_EQ:   cond_met = src_eq;
			BR_NE:   cond_met = !src_eq;
			BR_LT:   cond_met = src_lt;
			BR_GE:   cond_met = !src_lt;
			BR_LTU:  cond_met = src_ltu;
			BR_GEU:  cond_met = !src_ltu;
			default: cond_met = 1'b0;
		endcase
	end

	assign branch_taken = ctrl.is_branch && cond_met;

	// load/store address doubles as the jalr sum
	assign mem_addr = src1 + imm;
	assign target   = ctrl.is_jalr ? {mem_addr[31:1], 1'b0} : pc + imm;

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

	// base opcodes of the supported subset
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// system instructions recognized by the full word
	localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INST_MRET   = 32'h3020_0073;

	localparam logic [11:0] CSR_MSTATUS = 12'h300;
	localparam logic [11:0] CSR_MTVEC   = 12'h305;
	localparam logic [11:0] CSR_MEPC    = 12'h341;
	localparam logic [11:0] CSR_MCAUSE  = 12'h342;

	// environment call from M-mode
	localparam logic [31:0] MCAUSE_ECALL_M = 32'd11;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_s;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_s;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_s;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_s;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_s;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_s;

	// one instruction word, six ways to read it
	typedef union packed {
		r_fmt_s r_fmt;
		i_fmt_s i_fmt;
		s_fmt_s s_fmt;
		b_fmt_s b_fmt;
		u_fmt_s u_fmt;
		j_fmt_s j_fmt;
	} rv_inst_u;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_SLT,
		ALU_SLTU
	} alu_op_e;

	typedef enum logic [2:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4,
		WB_IMM,
		WB_CSR
	} wb_sel_e;

	typedef enum logic [1:0] {
		MEM_BYTE,
		MEM_HALF,
		MEM_WORD
	} mem_size_e;

	// encoded as funct3 so decode can cast directly
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} branch_cond_e;

	typedef enum logic [1:0] {
		CSR_NONE,
		CSR_RW,
		CSR_RS
	} csr_op_e;

	typedef struct packed {
		alu_op_e      alu_op;
		logic         src1_is_pc;
		logic         src2_is_imm;
		logic         reg_wen;
		wb_sel_e      wb_sel;
		logic         is_load;
		logic         is_store;
		mem_size_e    mem_size;
		logic         load_unsigned;
		logic         is_branch;
		branch_cond_e branch_cond;
		logic         is_jal;
		logic         is_jalr;
		csr_op_e      csr_op;
		logic         is_ecall;
		logic         is_mret;
		logic         is_ebreak;
	} ctrl_s;

	typedef struct packed {
		logic [29:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wmask;
		logic        wen;
		logic        ren;
	} dmem_req_s;

endpackage

// ==== logic/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile (
	input  logic        clk,
	input  logic        wen,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata,
	input  logic [4:0]  raddr1,
	input  logic [4:0]  raddr2,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	// x1..x31, x0 has no storage
	logic [31:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (wen && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// asynchronous reads
	assign rdata1 = (raddr1 == 5'd0) ? 32'h0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? 32'h0 : regs[raddr2];

endmodule

// ==== logic/rv_retire.sv ====
`timescale 1ns/100ps

module rv_retire import rv_pkg::*; #(
	parameter logic [31:0] RESET_VECTOR = 32'h8000_0000
) (
	input  logic        clk,
	input  logic        reset,
	input  ctrl_s       ctrl,
	input  logic [31:0] imm,
	input  logic [31:0] src2,
	input  logic [31:0] alu_result,
	input  logic        branch_taken,
	input  logic [31:0] target,
	input  logic [31:0] mem_addr,
	input  logic [31:0] csr_rdata,
	input  logic [31:0] trap_pc,
	input  logic [31:0] dmem_rdata,
	output logic [31:0] pc,
	output dmem_req_s   dmem_req,
	output logic        reg_wen,
	output logic [31:0] wb_data
);

	logic [31:0] pc_plus4;
	logic [31:0] next_pc;
	logic [31:0] store_data;
	logic [3:0]  store_mask;
	logic [7:0]  load_byte;
	logic [15:0] load_half;
	logic [31:0] load_data;

	assign pc_plus4 = pc + 32'd4;

	// traps first, then jumps and taken branches
	always_comb begin
		if (ctrl.is_ecall || ctrl.is_mret) begin
			next_pc = trap_pc;
		end else if (ctrl.is_jal || ctrl.is_jalr || branch_taken) begin
			next_pc = target;
		end else begin
			next_pc = pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= RESET_VECTOR;
		end else begin
			pc <= next_pc;
		end
	end

	// replicate the data, the mask picks the lane
	always_comb begin
		case (ctrl.mem_size)
			MEM_BYTE: begin
				store_data = {4{src2[7:0]}};
				store_mask = 4'b0001 << mem_addr[1:0];
			end
			MEM_HALF: begin
				store_data = {2{src2[15:0]}};
				store_mask = mem_addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				store_data = src2;
				store_mask = 4'b1111;
			end
		endcase
	end

	assign dmem_req.addr  = mem_addr[31:2];
	assign dmem_req.wdata = store_data;
	assign dmem_req.wmask = ctrl.is_store ? store_mask : 4'b0000;
	assign dmem_req.wen   = ctrl.is_store;
	assign dmem_req.ren   = ctrl.is_load;

	assign load_byte = dmem_rdata[{mem_addr[1:0], 3'b000} +: 8];
	assign load_half = dmem_rdata[{mem_addr[1], 4'b0000} +: 16];

	always_comb begin
		case (ctrl.mem_size)
			MEM_BYTE: load_data = ctrl.load_unsigned ? {24'h0, load_byte} :
					{{24{load_byte[7]}}, load_byte};
			MEM_HALF: load_data = ctrl.load_unsigned ? {16'h0, load_half} :
					{{16{load_half[15]}}, load_half};
			default:  load_data = dmem_rdata;
		endcase
	end

	always_comb begin
		case (ctrl.wb_sel)
			WB_MEM:  wb_data = load_data;
			WB_PC4:  wb_data = pc_plus4;
			WB_IMM:  wb_data = imm;
			WB_CSR:  wb_data = csr_rdata;
			default: wb_data = alu_result;
		endcase
	end

	assign reg_wen = ctrl.reg_wen;

endmodule

// ==== rv_core.f ====
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_csr_file.sv
logic/rv_retire.sv
logic/rv_core.sv
tb/rv_core_assertions.sv
tb/rv_core_tb.sv

// ==== tb/rv_core_assertions.sv ====
`timescale 1ns/100ps

module rv_core_assertions import rv_pkg::*; (
	input logic        clk,
	input logic        reset,
	input logic [31:0] imem_addr,
	input dmem_req_s   dmem_req,
	input ctrl_s       ctrl,
	input logic        branch_taken
);

	logic redirect;

	assign redirect = ctrl.is_jal || ctrl.is_jalr || branch_taken || ctrl.is_ecall ||
			ctrl.is_mret;

	no_read_write: assert property (@(posedge clk) disable iff (reset)
			!(dmem_req.wen && dmem_req.ren))
		else $error("load and store requested together");

	store_has_mask: assert property (@(posedge clk) disable iff (reset)
			dmem_req.wen |-> dmem_req.wmask != 4'b0000)
		else $error("store with empty byte mask");

	fetch_aligned: assert property (@(posedge clk) disable iff (reset)
			imem_addr[1:0] == 2'b00)
		else $error("instruction address not word aligned");

	// straight-line flow, starting from the first cycle out of reset
	sequential_fetch: assert property (@(posedge clk) disable iff (reset)
			!reset && !redirect |=> imem_addr == $past(imem_addr) + 32'd4)
		else $error("pc did not advance by 4");

endmodule

bind rv_core rv_core_assertions u_assertions (
	.clk          (clk),
	.reset        (reset),
	.imem_addr    (imem_addr),
	.dmem_req     (dmem_req),
	.ctrl         (ctrl),
	.branch_taken (branch_taken)
);

// ==== tb/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb import rv_pkg::*; ();

	localparam logic [31:0] RV = 32'h8000_0000;
	localparam logic [31:0] NOP = 32'h0000_0013;
	localparam int MAX_ROWS = 160;

	typedef struct packed {
		logic [31:0] inst;
		logic        wen;
		logic        ren;
		logic [29:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wmask;
		logic        halt;
		logic [31:0] next_pc;
	} row_s;

	logic        clk;
	logic        reset;
	logic [31:0] imem_addr;
	logic [31:0] imem_rdata;
	dmem_req_s   dmem_req;
	logic [31:0] dmem_rdata;
	logic        halt;

	row_s        prog [0:MAX_ROWS-1];
	int          nrows;
	logic [31:0] dmem [0:255];
	// shadow state used while building the table
	logic [31:0] xr [0:31];
	logic [31:0] smem [0:255];
	logic [31:0] m_mstatus;
	logic [31:0] m_mtvec;
	logic [31:0] m_mepc;
	logic [31:0] m_mcause;
	logic [31:0] lfsr;
	int          slot;
	int          errors;
	int          checks;
	logic        built;

	rv_core #(.RESET_VECTOR(RV)) DUT (
		.clk        (clk),
		.reset      (reset),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_req   (dmem_req),
		.dmem_rdata (dmem_rdata),
		.halt       (halt)
	);

	always #20 clk = ~clk;

	// instruction memory from the table
	always_comb begin
		int idx;
		idx = int'((imem_addr - RV) >> 2);
		if (imem_addr >= RV && idx < nrows)
			imem_rdata = prog[idx].inst;
		else
			imem_rdata = NOP;
	end

	assign dmem_rdata = dmem[dmem_req.addr[7:0]];

	always @(posedge clk) begin
		if (!reset && dmem_req.wen) begin
			for (int b = 0; b < 4; b++)
				if (dmem_req.wmask[b])
					dmem[dmem_req.addr[7:0]][8*b +: 8] <= dmem_req.wdata[8*b +: 8];
		end
	end

	function automatic logic [31:0] fill_word(input int i);
		return (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
	endfunction

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] sx12(input logic [11:0] i);
		return {{20{i[11]}}, i};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'h0, $signed(a) < $signed(b)};
			3'b011: return {31'h0, a < b};
			3'b100: return a ^ b;
			3'b101: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] pc_of(input int n);
		return RV + 32'(4 * n);
	endfunction

	task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
		if (rd != 5'd0)
			xr[rd] = v;
	endtask

	task automatic add_row(input logic [31:0] inst, input logic wen, input logic ren,
			input logic [31:0] baddr, input logic [31:0] wdata, input logic [3:0] wmask,
			input logic hlt, input logic [31:0] next_pc);
		prog[nrows] = '{inst, wen, ren, baddr[31:2], wdata, wmask, hlt, next_pc};
		nrows++;
	endtask

	task automatic add_plain(input logic [31:0] inst);
		add_row(inst, 1'b0, 1'b0, '0, '0, 4'h0, 1'b0, pc_of(nrows) + 32'd4);
	endtask

	task automatic do_lui(input logic [4:0] rd, input logic [19:0] imm);
		set_reg(rd, {imm, 12'h000});
		add_plain({imm, rd, 7'b0110111});
	endtask

	task automatic do_auipc(input logic [4:0] rd, input logic [19:0] imm);
		set_reg(rd, pc_of(nrows) + {imm, 12'h000});
		add_plain({imm, rd, 7'b0010111});
	endtask

	task automatic do_opimm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		logic alt;
		alt = (f3 == 3'b101) && imm[10];
		set_reg(rd, alu_ref(f3, alt, xr[rs1], sx12(imm)));
		add_plain({imm, rs1, f3, rd, 7'b0010011});
	endtask

	task automatic do_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		set_reg(rd, alu_ref(f3, alt, xr[rs1], xr[rs2]));
		add_plain({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011});
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800;
		do_lui(rd, hi[31:12]);
		do_opimm(3'b000, rd, rd, v[11:0]);
	endtask

	// stores use x0 as base, off is the byte address
	task automatic do_store(input logic [2:0] f3, input logic [4:0] rs2, input logic [11:0] off);
		logic [31:0] wdata;
		logic [3:0]  mask;
		logic [7:0]  widx;
		widx = off[9:2];
		if (f3 == 3'b000) begin
			wdata = {24'h0, xr[rs2][7:0]} << (8 * off[1:0]);
			mask  = 4'b0001 << off[1:0];
		end else if (f3 == 3'b001) begin
			wdata = {16'h0, xr[rs2][15:0]} << (16 * off[1]);
			mask  = off[1] ? 4'b1100 : 4'b0011;
		end else begin
			wdata = xr[rs2];
			mask  = 4'b1111;
		end
		for (int b = 0; b < 4; b++)
			if (mask[b])
				smem[widx][8*b +: 8] = wdata[8*b +: 8];
		add_row({off[11:5], rs2, 5'd0, f3, off[4:0], 7'b0100011}, 1'b1, 1'b0, {20'h0, off},
				wdata, mask, 1'b0, pc_of(nrows) + 32'd4);
	endtask

	task automatic expose(input logic [4:0] rs);
		do_store(3'b010, rs, 12'(slot));
		slot += 4;
	endtask

	task automatic do_load(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] off);
		logic [31:0] w;
		logic [7:0]  b;
		logic [15:0] h;
		w = smem[off[9:2]];
		b = w[8*off[1:0] +: 8];
		h = w[16*off[1] +: 16];
		case (f3)
			3'b100: set_reg(rd, {24'h0, b});
			3'b001: set_reg(rd, {{16{h[15]}}, h});
			3'b101: set_reg(rd, {16'h0, h});
			default: set_reg(rd, w);
		endcase
		add_row({off, 5'd0, f3, rd, 7'b0000011}, 1'b0, 1'b1, {20'h0, off}, '0, 4'h0, 1'b0,
				pc_of(nrows) + 32'd4);
	endtask

	// offset +8 over a filler nop
	task automatic do_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
		logic taken;
		taken = branch_ref(f3, xr[rs1], xr[rs2]);
		add_row({1'b0, 6'b0, rs2, rs1, f3, 4'b0100, 1'b0, 7'b1100011}, 1'b0, 1'b0, '0, '0,
				4'h0, 1'b0, pc_of(nrows) + (taken ? 32'd8 : 32'd4));
		add_plain(NOP);
	endtask

	function automatic logic [31:0] csr_get(input logic [11:0] a);
		case (a)
			CSR_MSTATUS: return m_mstatus;
			CSR_MTVEC:   return m_mtvec;
			CSR_MEPC:    return m_mepc;
			default:     return m_mcause;
		endcase
	endfunction

	task automatic do_csr(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] a);
		logic [31:0] old;
		logic [31:0] nv;
		old = csr_get(a);
		nv = (f3 == 3'b001) ? xr[rs1] : (old | xr[rs1]);
		case (a)
			CSR_MSTATUS: m_mstatus = nv;
			CSR_MTVEC:   m_mtvec = nv;
			CSR_MEPC:    m_mepc = {nv[31:2], 2'b00};
			default:     m_mcause = nv;
		endcase
		set_reg(rd, old);
		add_plain({a, rs1, f3, rd, 7'b1110011});
	endtask

	task automatic build_program();
		logic [31:0] v;
		logic [31:0] t;
		logic [2:0]  f3;
		logic [2:0]  br [0:5];
		br = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		for (int i = 0; i < 32; i++)
			xr[i] = '0;
		for (int i = 0; i < 256; i++)
			smem[i] = fill_word(i);
		// operands
		take_bits(32, v);
		load_const(5'd1, v);
		take_bits(32, v);
		load_const(5'd2, v ^ 32'h8000_0000);
		for (int k = 0; k < 8; k++) begin
			f3 = 3'(k);
			do_op(f3, 1'b0, 5'd3, 5'd1, 5'd2);
			expose(5'd3);
		end
		do_op(3'b000, 1'b1, 5'd3, 5'd1, 5'd2);
		expose(5'd3);
		do_op(3'b101, 1'b1, 5'd3, 5'd1, 5'd2);
		expose(5'd3);
		for (int k = 0; k < 8; k++) begin
			f3 = 3'(k);
			take_bits(12, v);
			if (f3 == 3'b001 || f3 == 3'b101)
				v = {20'h0, 7'b0, v[4:0]};
			do_opimm(f3, 5'd3, 5'd1, v[11:0]);
			expose(5'd3);
		end
		take_bits(5, v);
		do_opimm(3'b101, 5'd3, 5'd1, {7'b0100000, v[4:0]});
		expose(5'd3);
		take_bits(20, v);
		do_lui(5'd4, v[19:0]);
		expose(5'd4);
		take_bits(20, v);
		do_auipc(5'd4, v[19:0]);
		expose(5'd4);
		// each condition, taken and untaken
		for (int k = 0; k < 6; k++) begin
			if (k < 2) begin
				do_branch(br[k], 5'd1, 5'd1);
				do_branch(br[k], 5'd1, 5'd2);
			end else begin
				do_branch(br[k], 5'd1, 5'd2);
				do_branch(br[k], 5'd2, 5'd1);
			end
		end
		set_reg(5'd5, pc_of(nrows) + 32'd4);
		add_row({1'b0, 10'd4, 1'b0, 8'd0, 5'd5, 7'b1101111}, 1'b0, 1'b0, '0, '0, 4'h0, 1'b0,
				pc_of(nrows) + 32'd8);
		add_plain(NOP);
		expose(5'd5);
		// jalr with bit 0 set in the sum
		t = pc_of(nrows + 2) + 32'd8;
		load_const(5'd6, t);
		set_reg(5'd7, pc_of(nrows) + 32'd4);
		add_row({12'd1, 5'd6, 3'b000, 5'd7, 7'b1100111}, 1'b0, 1'b0, '0, '0, 4'h0, 1'b0, t);
		add_plain(NOP);
		expose(5'd7);
		// byte and half lanes
		take_bits(32, v);
		load_const(5'd8, v | 32'h8080_8080);
		do_store(3'b010, 5'd8, 12'h104);
		do_store(3'b000, 5'd8, 12'h105);
		do_store(3'b001, 5'd8, 12'h10a);
		do_store(3'b000, 5'd8, 12'h113);
		do_store(3'b001, 5'd8, 12'h118);
		do_load(3'b100, 5'd9, 12'h105);
		expose(5'd9);
		do_load(3'b001, 5'd10, 12'h10a);
		expose(5'd10);
		do_load(3'b101, 5'd11, 12'h10a);
		expose(5'd11);
		do_load(3'b010, 5'd12, 12'h104);
		expose(5'd12);
		// csr write and set
		take_bits(32, v);
		load_const(5'd13, v);
		do_csr(3'b001, 5'd0, 5'd13, CSR_MTVEC);
		take_bits(32, v);
		load_const(5'd14, v);
		do_csr(3'b010, 5'd15, 5'd14, CSR_MTVEC);
		do_csr(3'b010, 5'd16, 5'd0, CSR_MTVEC);
		expose(5'd15);
		expose(5'd16);
		// ecall into a handler right after it
		t = pc_of(nrows + 3) + 32'd8;
		load_const(5'd17, t);
		do_csr(3'b001, 5'd0, 5'd17, CSR_MTVEC);
		m_mepc = pc_of(nrows);
		m_mcause = 32'd11;
		add_row(32'h0000_0073, 1'b0, 1'b0, '0, '0, 4'h0, 1'b0, {m_mtvec[31:2], 2'b00});
		add_plain(NOP);
		do_csr(3'b010, 5'd18, 5'd0, CSR_MEPC);
		expose(5'd18);
		do_csr(3'b010, 5'd19, 5'd0, CSR_MCAUSE);
		expose(5'd19);
		t = pc_of(nrows + 3) + 32'd8;
		load_const(5'd20, t);
		do_csr(3'b001, 5'd0, 5'd20, CSR_MEPC);
		add_row(32'h3020_0073, 1'b0, 1'b0, '0, '0, 4'h0, 1'b0, m_mepc);
		add_plain(NOP);
		add_row(32'h0010_0073, 1'b0, 1'b0, '0, '0, 4'h0, 1'b1, pc_of(nrows) + 32'd4);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s got %h expected %h", name, got, exp);
		end
	endtask

	initial begin
		wait (built);
		#(nrows * 40 + 20 * 40);
		$display("timeout, the program did not reach ebreak in time");
		$display("sim failed");
		$finish;
	end

	initial begin
		logic [31:0] pc_exp;
		int          idx;
		int          steps;
		logic        done;
		row_s        r;
		clk = 1'b0;
		reset = 1'b1;
		built = 1'b0;
		lfsr = 32'h4ad2;
		nrows = 0;
		slot = 'h200;
		errors = 0;
		checks = 0;
		m_mstatus = '0;
		m_mtvec = '0;
		m_mepc = '0;
		m_mcause = '0;
		for (int i = 0; i < 256; i++)
			dmem[i] = fill_word(i);
		build_program();
		built = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		pc_exp = RV;
		steps = 0;
		done = 1'b0;
		while (!done && steps < nrows) begin
			@(negedge clk);
			idx = int'((pc_exp - RV) >> 2);
			if (pc_exp < RV || idx >= nrows) begin
				errors++;
				$display("predicted pc %h lies outside the program table", pc_exp);
				break;
			end
			r = prog[idx];
			check("imem_addr", imem_addr, pc_exp);
			check("dmem_req.wen", {31'h0, dmem_req.wen}, {31'h0, r.wen});
			check("dmem_req.ren", {31'h0, dmem_req.ren}, {31'h0, r.ren});
			if (r.wen || r.ren)
				check("dmem_req.addr", {2'b00, dmem_req.addr}, {2'b00, r.addr});
			if (r.wen) begin
				check("dmem_req.wmask", {28'h0, dmem_req.wmask}, {28'h0, r.wmask});
				for (int b = 0; b < 4; b++)
					if (r.wmask[b])
						check("dmem_req.wdata", {24'h0, dmem_req.wdata[8*b +: 8]},
								{24'h0, r.wdata[8*b +: 8]});
			end
			check("halt", {31'h0, halt}, {31'h0, r.halt});
			done = r.halt;
			pc_exp = r.next_pc;
			steps++;
		end
		if (!done) begin
			errors++;
			$display("program ended without reaching ebreak");
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule
